//--- raycast_params.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fixed-point format and screen layout shared by every ray caster file
// The column boundaries assume a 640 wide screen with 512 traced columns
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef RAYCAST_PARAMS_SVH
`define RAYCAST_PARAMS_SVH

// Signed fixed point, integer and fraction bits
`define Q_INT 12
`define Q_FRAC 12
`define Q_W (`Q_INT + `Q_FRAC)

// Map is 2^MAP_BITS cells on each side
`define MAP_BITS 4

// Column counter and the traced window inside the screen
`define COL_BITS 10
`define COL_FIRST_TRACE 64
`define COL_LAST_TRACE 575
`define COL_LAST 639

// Tallest column the display can show
`define HEIGHT_MAX 240

// Ray offset carries 256 columns per side of the centre, hence a shift of 8
`define RAY_SHIFT 8

`endif

//--- raycast_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Types only, the sizes come from raycast_params.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "raycast_params.svh"

package raycast_pkg;

    // One fixed-point word, seen either as a signed number or as its two fields
    // The field view only makes sense for non-negative values
    typedef union packed {
        logic signed [`Q_W-1:0] raw;
        struct packed {
            logic [`Q_INT-1:0]  intPart;
            logic [`Q_FRAC-1:0] fracPart;
        } part;
    } fixedT;

    // Cell index along one map axis, wraps at the map edge
    typedef logic [`MAP_BITS-1:0] mapCoordT;

endpackage

//--- reciprocal.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Single-cycle divider, long combinational path
// The sign of the input is dropped, the result is never negative
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "raycast_params.svh"

module reciprocal (
    input  raycast_pkg::fixedT i_value,
    output raycast_pkg::fixedT o_recip
);

    // 1.0 divided by a fixed-point value needs a dividend of 2^(2*Q_FRAC)
    localparam int divW = 2 * `Q_FRAC + 1;
    localparam logic [`Q_W-1:0] maxPos = {1'b0, {(`Q_W-1){1'b1}}};

    logic [`Q_W-1:0] absVal;
    logic [`Q_W:0]   remainder;
    logic [divW-1:0] quotient;

    // The most negative input still maps onto its true magnitude as unsigned
    assign absVal = i_value.raw[`Q_W-1] ? -i_value.raw : i_value.raw;

    // Restoring division, one quotient bit per pass from the top down
    always_comb begin
        remainder = '0;
        quotient  = '0;
        for (int bitIdx = divW - 1; bitIdx >= 0; bitIdx--) begin
            // Only the top dividend bit is set
            remainder = {remainder[`Q_W-1:0], (bitIdx == divW - 1)};
            if (remainder >= {1'b0, absVal}) begin
                remainder        = remainder - {1'b0, absVal};
                quotient[bitIdx] = 1'b1;
            end
        end
    end

    // Division by zero and results past the signed range both saturate
    assign o_recip = (absVal == '0 || quotient > divW'(maxPos)) ?
                     maxPos : quotient[`Q_W-1:0];

endmodule

//--- ddaStepper.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Player position must be non-negative and inside the map
// The map wraps, so a ray only stops on a wall cell
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "raycast_params.svh"

module ddaStepper (
    input  logic                  clk,
    input  logic                  i_rstN,
    input  logic                  i_rayStart,
    input  raycast_pkg::fixedT    i_rayDirX,
    input  raycast_pkg::fixedT    i_rayDirY,
    input  raycast_pkg::fixedT    i_playerX,
    input  raycast_pkg::fixedT    i_playerY,
    output raycast_pkg::mapCoordT o_mapCol,
    output raycast_pkg::mapCoordT o_mapRow,
    input  logic [1:0]            i_mapVal,
    output logic                  o_hit,
    output logic                  o_side,
    output raycast_pkg::fixedT    o_wallDist
);

    localparam logic [1:0] stIdle  = 2'd0;
    localparam logic [1:0] stStep  = 2'd1;
    localparam logic [1:0] stCheck = 2'd2;
    localparam logic [`Q_W-1:0] fixOne = `Q_W'(1) << `Q_FRAC;

    logic [1:0]            state;
    logic                  dirXPos;
    logic                  dirYPos;
    logic                  dirXPosQ;
    logic                  dirYPosQ;
    logic                  advanceX;
    raycast_pkg::fixedT    recipX;
    raycast_pkg::fixedT    recipY;
    raycast_pkg::fixedT    fracX;
    raycast_pkg::fixedT    fracY;
    raycast_pkg::fixedT    partialX;
    raycast_pkg::fixedT    partialY;
    logic [2*`Q_W-1:0]     initProdX;
    logic [2*`Q_W-1:0]     initProdY;
    raycast_pkg::fixedT    stepDistX;
    raycast_pkg::fixedT    stepDistY;
    raycast_pkg::fixedT    trackX;
    raycast_pkg::fixedT    trackY;
    raycast_pkg::mapCoordT mapX;
    raycast_pkg::mapCoordT mapY;

    // Distance along the ray to cross one whole cell on each axis
    reciprocal stepX (.i_value(i_rayDirX), .o_recip(recipX));
    reciprocal stepY (.i_value(i_rayDirY), .o_recip(recipY));

    assign dirXPos = i_rayDirX.raw > 0;
    assign dirYPos = i_rayDirY.raw > 0;

    // Fraction of the player position as a full word with a zero integer part
    assign fracX = {{`Q_INT{1'b0}}, i_playerX.part.fracPart};
    assign fracY = {{`Q_INT{1'b0}}, i_playerY.part.fracPart};

    // Part of the first cell still to cross, 1.0 is possible when the fraction is zero
    assign partialX = dirXPos ? fixOne - fracX.raw : fracX.raw;
    assign partialY = dirYPos ? fixOne - fracY.raw : fracY.raw;

    // Both factors are non-negative, so the middle of the product is the track start
    assign initProdX = recipX.raw * partialX.raw;
    assign initProdY = recipY.raw * partialY.raw;

    // Ties go to the Y axis
    assign advanceX = trackX.raw < trackY.raw;

    always_ff @(posedge clk) begin
        if (!i_rstN) begin
            state  <= stIdle;
            o_side <= 1'b0;
        end else if (i_rayStart) begin
            // A new ray always wins, even over a ray still in flight
            state <= stStep;
        end else begin
            case (state)
                stStep: begin
                    o_side <= !advanceX;
                    state  <= stCheck;
                end
                stCheck: begin
                    state <= (i_mapVal != 2'd0) ? stIdle : stStep;
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

    // Ray datapath, loaded at ray start and walked on step cycles
    always_ff @(posedge clk) begin
        if (i_rayStart) begin
            mapX      <= i_playerX.part.intPart[`MAP_BITS-1:0];
            mapY      <= i_playerY.part.intPart[`MAP_BITS-1:0];
            trackX    <= initProdX[`Q_FRAC +: `Q_W];
            trackY    <= initProdY[`Q_FRAC +: `Q_W];
            // Kept so the wall distance does not move when the camera offset does
            stepDistX <= recipX;
            stepDistY <= recipY;
            dirXPosQ  <= dirXPos;
            dirYPosQ  <= dirYPos;
        end else if (state == stStep) begin
            if (advanceX) begin
                mapX   <= dirXPosQ ? mapX + 1'b1 : mapX - 1'b1;
                trackX <= trackX.raw + stepDistX.raw;
            end else begin
                mapY   <= dirYPosQ ? mapY + 1'b1 : mapY - 1'b1;
                trackY <= trackY.raw + stepDistY.raw;
            end
        end
    end

    // The ROM sees the cell stepped into, and answers within the check cycle
    assign o_mapCol = mapX;
    assign o_mapRow = mapY;

    // A start in the same cycle cancels a stale hit of the previous ray
    assign o_hit = (state == stCheck) && (i_mapVal != 2'd0) && !i_rayStart;

    // Perpendicular distance is the track before its last step
    assign o_wallDist = o_side ? trackY.raw - stepDistY.raw : trackX.raw - stepDistX.raw;

endmodule

//--- wallHeight.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reference wall height is 256, output is clamped to HEIGHT_MAX
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "raycast_params.svh"

module wallHeight (
    input  raycast_pkg::fixedT i_wallDist,
    output logic [7:0]         o_height
);

    raycast_pkg::fixedT scale;
    logic               tallWall;
    logic [7:0]         rawHeight;

    // Height is proportional to one over the distance
    reciprocal scaler (
        .i_value(i_wallDist),
        .o_recip(scale)
    );

    // The scale is never negative, so any integer bit means 1.0 or more
    assign tallWall = scale.part.intPart != '0;

    // With a reference of 256 the height is just the top fraction byte
    assign rawHeight = tallWall ? 8'd255 : scale.part.fracPart[`Q_FRAC-1 -: 8];

    // Heights above the visible limit are cut down to it
    assign o_height = (rawHeight > 8'(`HEIGHT_MAX)) ? 8'(`HEIGHT_MAX) : rawHeight;

endmodule

//--- columnSequencer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Camera inputs must be held while i_enable is high
// One frame per rise of i_enable, no back-pressure on stores
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "raycast_params.svh"

module columnSequencer (
    input  logic                 clk,
    input  logic                 i_rstN,
    input  logic                 i_enable,
    input  raycast_pkg::fixedT   i_vplaneX,
    input  raycast_pkg::fixedT   i_vplaneY,
    input  raycast_pkg::fixedT   i_facingX,
    input  raycast_pkg::fixedT   i_facingY,
    input  logic                 i_hit,
    output logic                 o_rayStart,
    output raycast_pkg::fixedT   o_rayDirX,
    output raycast_pkg::fixedT   o_rayDirY,
    output logic                 o_store,
    output logic [`COL_BITS-1:0] o_column,
    output logic                 o_deadCol,
    output logic                 o_frameDone
);

    localparam logic [2:0] stLeftClear  = 3'd0;
    localparam logic [2:0] stRayStart   = 3'd1;
    localparam logic [2:0] stWaitHit    = 3'd2;
    localparam logic [2:0] stStore      = 3'd3;
    localparam logic [2:0] stRightClear = 3'd4;
    localparam logic [2:0] stDone       = 3'd5;

    logic [2:0]           state;
    logic [`COL_BITS-1:0] colCount;
    raycast_pkg::fixedT   rayAddX;
    raycast_pkg::fixedT   rayAddY;

    // Offset runs from -256 to +256 view planes and is scaled back here
    assign o_rayDirX = i_facingX.raw + (rayAddX.raw >>> `RAY_SHIFT);
    assign o_rayDirY = i_facingY.raw + (rayAddY.raw >>> `RAY_SHIFT);

    always_ff @(posedge clk) begin
        if (!i_rstN || !i_enable) begin
            // Start state, the leftmost column sits 256 view planes left of centre
            state       <= stLeftClear;
            colCount    <= '0;
            rayAddX     <= -i_vplaneX.raw <<< `RAY_SHIFT;
            rayAddY     <= -i_vplaneY.raw <<< `RAY_SHIFT;
            o_rayStart  <= 1'b0;
            o_store     <= 1'b0;
            o_column    <= '0;
            o_deadCol   <= 1'b0;
            o_frameDone <= 1'b0;
        end else begin
            case (state)
                stLeftClear: begin
                    // One dead column stored per cycle
                    o_store   <= 1'b1;
                    o_deadCol <= 1'b1;
                    o_column  <= colCount;
                    colCount  <= colCount + 1'b1;
                    if (colCount == `COL_BITS'(`COL_FIRST_TRACE - 1)) begin
                        state <= stRayStart;
                    end
                end
                stRayStart: begin
                    o_store    <= 1'b0;
                    o_deadCol  <= 1'b0;
                    o_rayStart <= 1'b1;
                    state      <= stWaitHit;
                end
                stWaitHit: begin
                    o_rayStart <= 1'b0;
                    if (i_hit) begin
                        o_store  <= 1'b1;
                        o_column <= colCount;
                        state    <= stStore;
                    end
                end
                stStore: begin
                    // Ray direction stays valid through the store, it moves on afterwards
                    o_store  <= 1'b0;
                    rayAddX  <= rayAddX.raw + i_vplaneX.raw;
                    rayAddY  <= rayAddY.raw + i_vplaneY.raw;
                    colCount <= colCount + 1'b1;
                    if (colCount == `COL_BITS'(`COL_LAST_TRACE)) begin
                        state <= stRightClear;
                    end else begin
                        state <= stRayStart;
                    end
                end
                stRightClear: begin
                    o_store   <= 1'b1;
                    o_deadCol <= 1'b1;
                    o_column  <= colCount;
                    colCount  <= colCount + 1'b1;
                    if (colCount == `COL_BITS'(`COL_LAST)) begin
                        state <= stDone;
                    end
                end
                stDone: begin
                    // Held here until i_enable drops
                    o_store     <= 1'b0;
                    o_deadCol   <= 1'b0;
                    o_frameDone <= 1'b1;
                end
                default: begin
                    state <= stLeftClear;
                end
            endcase
        end
    end

endmodule

//--- rayTracer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Map ROM must answer in the same cycle as its address
// Every o_store must be taken, there is no stall
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "raycast_params.svh"

module rayTracer (
    input  logic                  clk,
    input  logic                  i_rstN,
    input  logic                  i_enable,
    input  raycast_pkg::fixedT    i_playerX,
    input  raycast_pkg::fixedT    i_playerY,
    input  raycast_pkg::fixedT    i_facingX,
    input  raycast_pkg::fixedT    i_facingY,
    input  raycast_pkg::fixedT    i_vplaneX,
    input  raycast_pkg::fixedT    i_vplaneY,
    output raycast_pkg::mapCoordT o_mapCol,
    output raycast_pkg::mapCoordT o_mapRow,
    input  logic [1:0]            i_mapVal,
    output logic                  o_store,
    output logic [`COL_BITS-1:0]  o_column,
    output logic [7:0]            o_height,
    output logic                  o_side,
    output logic                  o_frameDone
);

    logic               rayStart;
    logic               hit;
    logic               deadCol;
    logic               hitSide;
    logic [7:0]         traceHeight;
    raycast_pkg::fixedT rayDirX;
    raycast_pkg::fixedT rayDirY;
    raycast_pkg::fixedT wallDist;

    columnSequencer u_sequencer (
        .clk        (clk),
        .i_rstN     (i_rstN),
        .i_enable   (i_enable),
        .i_vplaneX  (i_vplaneX),
        .i_vplaneY  (i_vplaneY),
        .i_facingX  (i_facingX),
        .i_facingY  (i_facingY),
        .i_hit      (hit),
        .o_rayStart (rayStart),
        .o_rayDirX  (rayDirX),
        .o_rayDirY  (rayDirY),
        .o_store    (o_store),
        .o_column   (o_column),
        .o_deadCol  (deadCol),
        .o_frameDone(o_frameDone)
    );

    ddaStepper u_stepper (
        .clk       (clk),
        .i_rstN    (i_rstN),
        .i_rayStart(rayStart),
        .i_rayDirX (rayDirX),
        .i_rayDirY (rayDirY),
        .i_playerX (i_playerX),
        .i_playerY (i_playerY),
        .o_mapCol  (o_mapCol),
        .o_mapRow  (o_mapRow),
        .i_mapVal  (i_mapVal),
        .o_hit     (hit),
        .o_side    (hitSide),
        .o_wallDist(wallDist)
    );

    wallHeight u_height (
        .i_wallDist(wallDist),
        .o_height  (traceHeight)
    );

    // Dead columns carry an empty result whatever the stepper last held
    assign o_height = deadCol ? 8'd0 : traceHeight;
    assign o_side   = deadCol ? 1'b0 : hitSide;

endmodule

//--- rayTracer_chk.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Protocol checks bound onto the rayTracer top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "raycast_params.svh"

module rayTracer_chk (
    input logic                 clk,
    input logic                 i_rstN,
    input logic                 o_store,
    input logic                 o_frameDone,
    input logic [`COL_BITS-1:0] o_column
);

    // A finished frame never stores another column
    storeNotWithDone: assert property (@(posedge clk) disable iff (!i_rstN)
        !(o_store && o_frameDone))
        else $error("o_store and o_frameDone high in the same cycle");

    // Stored columns stay on the screen
    columnInRange: assert property (@(posedge clk) disable iff (!i_rstN)
        o_store |-> (o_column <= `COL_BITS'(`COL_LAST)))
        else $error("o_column beyond the last screen column during a store");

    // Reset clears the store strobe on the next edge
    storeClearedByReset: assert property (@(posedge clk) !i_rstN |=> !o_store)
        else $error("o_store high in the cycle after reset");

endmodule

bind rayTracer rayTracer_chk u_chk (
    .clk        (clk),
    .i_rstN     (i_rstN),
    .o_store    (o_store),
    .o_frameDone(o_frameDone),
    .o_column   (o_column)
);

//--- tb_rayTracer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for rayTracer, eight frames with one cut short
// Vplane magnitude is kept small so the offset never wraps
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "raycast_params.svh"

module tb_rayTracer;

    localparam int frameCount = 8;
    localparam int cycleLimit = 60000 * frameCount;
    localparam longint maxPos = (longint'(1) << (`Q_W - 1)) - 1;

    logic                   clk;
    logic                   rstN;
    logic                   enable;
    logic signed [`Q_W-1:0] playerX;
    logic signed [`Q_W-1:0] playerY;
    logic signed [`Q_W-1:0] facingX;
    logic signed [`Q_W-1:0] facingY;
    logic signed [`Q_W-1:0] vplaneX;
    logic signed [`Q_W-1:0] vplaneY;
    logic [`MAP_BITS-1:0]   mapCol;
    logic [`MAP_BITS-1:0]   mapRow;
    logic [1:0]             mapVal;
    logic                   store;
    logic [`COL_BITS-1:0]   column;
    logic [7:0]             height;
    logic                   side;
    logic                   frameDone;

    int          expCol;
    int          storeCount;
    int          failCount;
    int          cycleCount;
    int unsigned lcgState;
    string       testName;
    logic [7:0]  heights [0:`COL_LAST];

    rayTracer i_rayTracer (
        .clk        (clk),
        .i_rstN     (rstN),
        .i_enable   (enable),
        .i_playerX  (playerX),
        .i_playerY  (playerY),
        .i_facingX  (facingX),
        .i_facingY  (facingY),
        .i_vplaneX  (vplaneX),
        .i_vplaneY  (vplaneY),
        .o_mapCol   (mapCol),
        .o_mapRow   (mapRow),
        .i_mapVal   (mapVal),
        .o_store    (store),
        .o_column   (column),
        .o_height   (height),
        .o_side     (side),
        .o_frameDone(frameDone)
    );

    // Border walls plus a few inner blocks
    function automatic logic [1:0] mapCell(input int row, input int col);
        if (row == 0 || row == 15 || col == 0 || col == 15) return 2'd1;
        if (row == 4 && (col == 4 || col == 5)) return 2'd2;
        if ((row == 10 || row == 11) && col == 10) return 2'd3;
        if (row == 12 && col == 7) return 2'd2;
        if (row == 3 && col == 12) return 2'd1;
        return 2'd0;
    endfunction

    // The ROM answers in the same cycle as its address
    assign mapVal = mapCell(mapRow, mapCol);

    function automatic int unsigned nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState >> 8;
    endfunction

    // Floor of 2^(2*Q_FRAC) over the magnitude, saturated at the largest positive word
    function automatic logic signed [`Q_W-1:0] reciprocalOf(input logic signed [`Q_W-1:0] v);
        longint magnitude;
        longint quot;
        magnitude = (v < 0) ? -longint'(v) : longint'(v);
        if (magnitude == 0) return maxPos;
        quot = (longint'(1) << (2 * `Q_FRAC)) / magnitude;
        if (quot > maxPos) return maxPos;
        return quot;
    endfunction

    // Expected {side, height} of one screen column for the current camera
    function automatic logic [8:0] traceColumn(input int col);
        logic signed [`Q_W-1:0] offX;
        logic signed [`Q_W-1:0] offY;
        logic signed [`Q_W-1:0] dirX;
        logic signed [`Q_W-1:0] dirY;
        logic signed [`Q_W-1:0] stepX;
        logic signed [`Q_W-1:0] stepY;
        logic signed [`Q_W-1:0] trackX;
        logic signed [`Q_W-1:0] trackY;
        logic signed [`Q_W-1:0] wallDist;
        logic signed [`Q_W-1:0] scale;
        logic [`MAP_BITS-1:0]   mx;
        logic [`MAP_BITS-1:0]   my;
        longint                 partX;
        longint                 partY;
        logic                   hitSide;
        logic                   hit;
        logic [7:0]             h;
        int                     guard;
        if (col < `COL_FIRST_TRACE || col > `COL_LAST_TRACE) return 9'd0;
        // Offset starts 256 view planes left and gains one view plane per traced column
        offX = -(vplaneX <<< `RAY_SHIFT) + (col - `COL_FIRST_TRACE) * vplaneX;
        offY = -(vplaneY <<< `RAY_SHIFT) + (col - `COL_FIRST_TRACE) * vplaneY;
        dirX = facingX + (offX >>> `RAY_SHIFT);
        dirY = facingY + (offY >>> `RAY_SHIFT);
        stepX = reciprocalOf(dirX);
        stepY = reciprocalOf(dirY);
        partX = playerX[`Q_FRAC-1:0];
        partY = playerY[`Q_FRAC-1:0];
        if (dirX > 0) partX = (longint'(1) << `Q_FRAC) - partX;
        if (dirY > 0) partY = (longint'(1) << `Q_FRAC) - partY;
        trackX = (longint'(stepX) * partX) >>> `Q_FRAC;
        trackY = (longint'(stepY) * partY) >>> `Q_FRAC;
        mx = playerX[`Q_FRAC +: `MAP_BITS];
        my = playerY[`Q_FRAC +: `MAP_BITS];
        hitSide = 1'b0;
        hit = 1'b0;
        guard = 0;
        // DDA walk, a tie between the tracks steps along Y
        while (!hit && guard < 256) begin
            if (trackX < trackY) begin
                mx = (dirX > 0) ? mx + 1'b1 : mx - 1'b1;
                trackX = trackX + stepX;
                hitSide = 1'b0;
            end else begin
                my = (dirY > 0) ? my + 1'b1 : my - 1'b1;
                trackY = trackY + stepY;
                hitSide = 1'b1;
            end
            hit = mapCell(my, mx) != 2'd0;
            guard++;
        end
        wallDist = hitSide ? trackY - stepY : trackX - stepX;
        scale = reciprocalOf(wallDist);
        h = (scale[`Q_W-1:`Q_FRAC] != '0) ? 8'd255 : scale[`Q_FRAC-1 -: 8];
        if (h > `HEIGHT_MAX) h = `HEIGHT_MAX;
        return {hitSide, h};
    endfunction

    task automatic checkValue(input string what, input longint expected, input longint actual);
        if (expected != actual) begin
            failCount++;
            $display("ERR %s: %s expected %0d actual %0d", testName, what, expected, actual);
            $display("Something failed");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // Random player in an empty cell, facing and a perpendicular view plane
    task automatic pickPose();
        int cellX;
        int cellY;
        int fx;
        int fy;
        do begin
            cellX = 1 + nextRand() % 14;
            cellY = 1 + nextRand() % 14;
        end while (mapCell(cellY, cellX) != 2'd0);
        playerX = (cellX << `Q_FRAC) | (nextRand() % 4096);
        playerY = (cellY << `Q_FRAC) | (nextRand() % 4096);
        fx = int'(nextRand() % 8193) - 4096;
        fy = int'(nextRand() % 8193) - 4096;
        if (fx > -1024 && fx < 1024 && fy > -1024 && fy < 1024) fx = 4096;
        facingX = fx;
        facingY = fy;
        // Roughly 0.66 of the facing length, turned by a quarter
        vplaneX = (-fy * 2703) / 4096;
        vplaneY = (fx * 2703) / 4096;
    endtask

    task automatic runFrame();
        storeCount = 0;
        @(posedge clk);
        #1 enable = 1'b1;
        do begin
            @(posedge clk);
            #1;
        end while (!frameDone);
        checkValue("stores per frame", 640, storeCount);
        // Done stays up for as long as enable is held high
        @(posedge clk);
        #1;
        checkValue("frame done held", 1, frameDone);
        enable = 1'b0;
        repeat (2) begin
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Run limit scaled by the number of frames
    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("Run did not finish within %0d cycles", cycleLimit);
            $display("Something failed");
            $fatal(1, "Timeout");
        end
    end

    // Every store is checked in mid-cycle, when all outputs are settled
    always @(negedge clk) begin
        logic [8:0] expected;
        if (rstN && store) begin
            expected = traceColumn(expCol);
            checkValue("column order", expCol, column);
            checkValue($sformatf("height of column %0d", expCol), expected[7:0], height);
            checkValue($sformatf("side of column %0d", expCol), expected[8], side);
            heights[expCol] = height;
            storeCount++;
            expCol++;
        end
        if (!enable) expCol = 0;
    end

    initial begin
        rstN = 1'b0;
        enable = 1'b0;
        playerX = '0;
        playerY = '0;
        facingX = '0;
        facingY = '0;
        vplaneX = '0;
        vplaneY = '0;
        expCol = 0;
        storeCount = 0;
        failCount = 0;
        cycleCount = 0;
        lcgState = 75572;
        testName = "reset";
        repeat (8) @(posedge clk);
        #1 rstN = 1'b1;

        for (int pose = 0; pose < 5; pose++) begin
            testName = $sformatf("random pose %0d", pose);
            pickPose();
            runFrame();
        end

        // Wall a quarter cell in front of the player
        testName = "wall clamp";
        playerX = (1 << `Q_FRAC) + 1024;
        playerY = (7 << `Q_FRAC) + 2048;
        facingX = -4096;
        facingY = 0;
        vplaneX = 0;
        vplaneY = 2703;
        runFrame();
        for (int c = 300; c <= 340; c++) begin
            checkValue($sformatf("clamped height of column %0d", c), `HEIGHT_MAX, heights[c]);
        end

        // Cut a frame short, then run it again from column 0
        testName = "restart";
        pickPose();
        storeCount = 0;
        // The sequencer takes the new view plane on an edge with enable low
        @(posedge clk);
        #1 enable = 1'b1;
        do begin
            @(posedge clk);
            #1;
        end while (expCol < 300);
        enable = 1'b0;
        repeat (3) begin
            @(posedge clk);
            #1;
        end
        runFrame();

        if (failCount == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+.
raycast_pkg.sv
reciprocal.sv
ddaStepper.sv
wallHeight.sv
columnSequencer.sv
rayTracer.sv
rayTracer_chk.sv
tb_rayTracer.sv
